/* logic/gic_pkg.sv */
// Widths, types and config layout shared by every block of the global interface controller
`default_nettype none

package gic_pkg;

    // ====================
    // Widths and depths
    // ====================
    localparam int BEATS_PER_WORD = 2;
    localparam int FIFO_DEPTH     = 2;
    localparam int PORT_W         = 16;
    localparam int WORD_W         = PORT_W * BEATS_PER_WORD;

    typedef logic [PORT_W-1:0]                   port_data_t;
    typedef logic [WORD_W-1:0]                   glb_word_t;
    typedef logic [7:0]                          glb_addr_t;
    typedef logic [7:0]                          word_count_t;
    typedef logic [15:0]                         dram_addr_t;
    typedef logic [$clog2(BEATS_PER_WORD)-1:0]   beat_idx_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0]       fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_cnt_t;

    // Index of the high half inside a word
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS_PER_WORD - 1);

    // ====================
    // Config word layout
    // ====================
    // LSB up: dir, num_words, dram_base, glb_base
    localparam int CFG_DIR_POS  = 0;
    localparam int CFG_NUM_LSB  = CFG_DIR_POS + 1;
    localparam int CFG_DRAM_LSB = CFG_NUM_LSB + $bits(word_count_t);
    localparam int CFG_GLB_LSB  = CFG_DRAM_LSB + $bits(dram_addr_t);
    localparam int CFG_W        = CFG_GLB_LSB + $bits(glb_addr_t);
    // Command beat is the config word minus glb_base
    localparam int CMD_W        = CFG_GLB_LSB;

    typedef logic [CFG_W-1:0] cfg_info_t;
    typedef logic [CMD_W-1:0] cmd_t;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_IN2CHIP,
        ST_OUT2OFF
    } gic_state_e;

    // Field extraction
    function automatic glb_addr_t cfg_glb_base(cfg_info_t cfg);
        return cfg[CFG_GLB_LSB +: $bits(glb_addr_t)];
    endfunction

    function automatic dram_addr_t cfg_dram_base(cfg_info_t cfg);
        return cfg[CFG_DRAM_LSB +: $bits(dram_addr_t)];
    endfunction

    function automatic word_count_t cfg_num_words(cfg_info_t cfg);
        return cfg[CFG_NUM_LSB +: $bits(word_count_t)];
    endfunction

    // 0 in to chip, 1 out to off-chip
    function automatic logic cfg_dir(cfg_info_t cfg);
        return cfg[CFG_DIR_POS];
    endfunction

endpackage

`default_nettype wire

/* logic/word_stream_if.sv */
// Valid/ready stream of one buffer word plus last flag, used between the data path blocks
`default_nettype none

interface word_stream_if
    import gic_pkg::*;
();

    // ====================
    // Stream signals
    // ====================
    // One buffer word, low half first on the port
    glb_word_t data;
    // Final word of the transfer
    logic      last;
    logic      vld;
    logic      rdy;

    // Producer side
    modport src (
        output data,
        output last,
        output vld,
        input  rdy
    );

    // Consumer side
    modport snk (
        input  data,
        input  last,
        input  vld,
        output rdy
    );

endinterface

`default_nettype wire

/* logic/gic_ctrl_fsm.sv */
// Controller FSM; takes the config word, sends the command beat and enables one data path
`default_nettype none

module gic_ctrl_fsm
    import gic_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_vld,
    input  cfg_info_t cfg_info,
    output logic      cfg_rdy,
    output logic      cmd_vld,
    output cmd_t      cmd,
    input  logic      cmd_rdy,
    input  logic      wr_last_fire,
    input  logic      out_last_fire,
    output logic      in_en,
    output logic      out_en,
    output logic      clear,
    output cfg_info_t cfg_q
);

    gic_state_e state;
    gic_state_e state_nxt;
    logic       cfg_fire;
    logic       cmd_fire;

    assign cfg_fire = cfg_vld && cfg_rdy;
    assign cmd_fire = cmd_vld && cmd_rdy;

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (cfg_fire) begin
                    state_nxt = ST_CMD;
                end
            end
            ST_CMD: begin
                // Direction picks the data path
                if (cmd_fire) begin
                    state_nxt = cfg_dir(cfg_q) ? ST_OUT2OFF : ST_IN2CHIP;
                end
            end
            ST_IN2CHIP: begin
                // Done on the last GLB write
                if (wr_last_fire) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_OUT2OFF: begin
                // Done when off-chip takes the last beat
                if (out_last_fire) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Config captured only while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (cfg_fire) begin
            cfg_q <= cfg_info;
        end
    end

    // ====================
    // Outputs
    // ====================
    assign cfg_rdy = (state == ST_IDLE);
    assign clear   = (state == ST_IDLE);
    assign cmd_vld = (state == ST_CMD);
    assign in_en   = (state == ST_IN2CHIP);
    assign out_en  = (state == ST_OUT2OFF);

    // Command beat from the registered fields
    assign cmd = {cfg_dram_base(cfg_q), cfg_num_words(cfg_q), cfg_dir(cfg_q)};

    // Zero-length transfer would never finish
    a_num_words_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_fire |-> (cfg_num_words(cfg_info) != '0));

    // One data path at a time, the one the stored direction selects
    a_one_path: assert property (@(posedge clk) disable iff (!rst_n)
        (in_en || out_en) |-> ({in_en, out_en} == {!cfg_dir(cfg_q), cfg_dir(cfg_q)}));

endmodule

`default_nettype wire

/* logic/glb_addr_counter.sv */
// Write, read-address and read-data word counters; give GLB offsets and end-of-transfer flags
`default_nettype none

module glb_addr_counter
    import gic_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  word_count_t num_words,
    input  logic        wr_fire,
    input  logic        rd_addr_fire,
    input  logic        rd_data_fire,
    output word_count_t wr_cnt,
    output word_count_t rd_addr_cnt,
    output logic        rd_issue_done,
    output logic        data_last
);

    // Read words already taken by the unpacker
    word_count_t rd_data_cnt;

    // ====================
    // Counters
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt      <= '0;
            rd_addr_cnt <= '0;
            rd_data_cnt <= '0;
        end else if (clear) begin
            wr_cnt      <= '0;
            rd_addr_cnt <= '0;
            rd_data_cnt <= '0;
        end else begin
            if (wr_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (rd_addr_fire) begin
                rd_addr_cnt <= rd_addr_cnt + 1'b1;
            end
            if (rd_data_fire) begin
                rd_data_cnt <= rd_data_cnt + 1'b1;
            end
        end
    end

    // All read addresses sent
    assign rd_issue_done = (rd_addr_cnt == num_words);
    // Word now arriving is the final one
    assign data_last     = (rd_data_cnt == word_count_t'(num_words - 1'b1));

    // Top must stop address requests at the count
    a_no_extra_addr: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr_fire |-> !rd_issue_done);

endmodule

`default_nettype wire

/* logic/port_to_word_packer.sv */
// Packs two off-chip port beats into one buffer word for the in-to-chip path
`default_nettype none

module port_to_word_packer
    import gic_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear,
    input  logic          in_en,
    input  port_data_t    in_dat,
    input  logic          in_vld,
    input  logic          in_last,
    output logic          in_rdy,
    word_stream_if.src    word_o
);

    beat_idx_t  beat_idx;
    logic       word_vld_q;
    port_data_t lo_q;
    glb_word_t  word_q;
    logic       last_q;
    logic       in_fire;
    logic       out_fire;

    // Stall input while a packed word waits
    assign in_rdy   = in_en && !word_vld_q;
    assign in_fire  = in_vld && in_rdy;
    assign out_fire = word_o.vld && word_o.rdy;

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx   <= '0;
            word_vld_q <= 1'b0;
        end else if (clear) begin
            beat_idx   <= '0;
            word_vld_q <= 1'b0;
        end else begin
            if (in_fire) begin
                beat_idx <= (beat_idx == LAST_BEAT) ? '0 : beat_idx + 1'b1;
            end
            // Word complete on the high beat
            if (in_fire && beat_idx == LAST_BEAT) begin
                word_vld_q <= 1'b1;
            end else if (out_fire) begin
                word_vld_q <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (in_fire && beat_idx != LAST_BEAT) begin
            lo_q <= in_dat;
        end
        if (in_fire && beat_idx == LAST_BEAT) begin
            word_q <= {in_dat, lo_q};
            // Last flag follows the high beat
            last_q <= in_last;
        end
    end

    assign word_o.data = word_q;
    assign word_o.last = last_q;
    assign word_o.vld  = word_vld_q;

endmodule

`default_nettype wire

/* logic/word_fifo.sv */
// First-word-fall-through FIFO between the packer and the GLB write port, flushed while idle
`default_nettype none

module word_fifo
    import gic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    word_stream_if.snk push_s,
    word_stream_if.src pop_s
);

    glb_word_t data_mem [FIFO_DEPTH];
    logic      last_mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      full;
    logic      empty;
    logic      push;
    logic      pop;

    assign full  = (count == FIFO_DEPTH);
    assign empty = (count == '0);
    assign push  = push_s.vld && push_s.rdy;
    assign pop   = pop_s.vld && pop_s.rdy;

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= push_s.data;
            last_mem[wr_ptr] <= push_s.last;
        end
    end

    // Head shown without a read cycle
    assign push_s.rdy = !full;
    assign pop_s.vld  = !empty;
    assign pop_s.data = data_mem[rd_ptr];
    assign pop_s.last = last_mem[rd_ptr];

    // Pointers meet only when the count says empty or full
    a_no_over_under: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr == rd_ptr) == (empty || full));

endmodule

`default_nettype wire

/* logic/word_to_port_unpacker.sv */
// Splits each GLB read word into two port beats for the out-to-off-chip path
`default_nettype none

module word_to_port_unpacker
    import gic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       out_en,
    input  glb_word_t  rd_dat,
    input  logic       rd_dat_vld,
    input  logic       data_last,
    output logic       rd_dat_rdy,
    output port_data_t out_dat,
    output logic       out_vld,
    output logic       out_last,
    input  logic       out_rdy
);

    glb_word_t word_q;
    logic      last_q;
    logic      full_q;
    beat_idx_t half_q;
    logic      in_fire;
    logic      out_fire;

    // One word at a time
    assign rd_dat_rdy = out_en && !full_q;
    assign in_fire    = rd_dat_vld && rd_dat_rdy;
    assign out_fire   = out_vld && out_rdy;

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
            half_q <= '0;
        end else if (clear) begin
            full_q <= 1'b0;
            half_q <= '0;
        end else if (in_fire) begin
            full_q <= 1'b1;
            half_q <= '0;
        end else if (out_fire) begin
            // Word released after its high half
            if (half_q == LAST_BEAT) begin
                full_q <= 1'b0;
                half_q <= '0;
            end else begin
                half_q <= half_q + 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (in_fire) begin
            word_q <= rd_dat;
            last_q <= data_last;
        end
    end

    // Low half first
    assign out_dat  = word_q[half_q * PORT_W +: PORT_W];
    assign out_vld  = full_q;
    // Only the high half of the final word
    assign out_last = full_q && last_q && (half_q == LAST_BEAT);

endmodule

`default_nettype wire

/* logic/gic_top.sv */
// Top level of the global interface controller; wires the FSM, counters and data paths to ports
`default_nettype none

module gic_top
    import gic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Config from the central control unit
    input  logic       cfg_vld,
    output logic       cfg_rdy,
    input  cfg_info_t  cfg_info,
    // Command beat
    output logic       cmd_vld,
    output cmd_t       cmd,
    input  logic       cmd_rdy,
    // Outbound port
    output port_data_t out_dat,
    output logic       out_vld,
    output logic       out_last,
    input  logic       out_rdy,
    // Inbound port
    input  port_data_t in_dat,
    input  logic       in_vld,
    input  logic       in_last,
    output logic       in_rdy,
    // GLB read
    output glb_addr_t  rd_addr,
    output logic       rd_addr_vld,
    input  logic       rd_addr_rdy,
    input  glb_word_t  rd_dat,
    input  logic       rd_dat_vld,
    output logic       rd_dat_rdy,
    // GLB write
    output glb_addr_t  wr_addr,
    output glb_word_t  wr_dat,
    output logic       wr_vld,
    input  logic       wr_rdy
);

    cfg_info_t   cfg_q;
    logic        in_en;
    logic        out_en;
    logic        clear;
    logic        wr_fire;
    logic        wr_last_fire;
    logic        out_last_fire;
    logic        rd_addr_fire;
    logic        rd_data_fire;
    logic        rd_issue_done;
    logic        data_last;
    word_count_t wr_cnt;
    word_count_t rd_addr_cnt;

    word_stream_if pack_s ();
    word_stream_if fifo_s ();

    // ====================
    // Handshakes
    // ====================
    assign wr_fire       = fifo_s.vld && fifo_s.rdy;
    assign wr_last_fire  = wr_fire && fifo_s.last;
    assign out_last_fire = out_vld && out_rdy && out_last;
    assign rd_addr_fire  = rd_addr_vld && rd_addr_rdy;
    assign rd_data_fire  = rd_dat_vld && rd_dat_rdy;

    // GLB write port straight from the FIFO head
    assign wr_dat     = fifo_s.data;
    assign wr_vld     = fifo_s.vld;
    assign fifo_s.rdy = wr_rdy;

    // Addresses wrap modulo 256
    assign wr_addr     = cfg_glb_base(cfg_q) + wr_cnt;
    assign rd_addr     = cfg_glb_base(cfg_q) + rd_addr_cnt;
    assign rd_addr_vld = out_en && !rd_issue_done;

    // ====================
    // Instances
    // ====================
    gic_ctrl_fsm ctrl_i (
        .clk, .rst_n, .cfg_vld, .cfg_info, .cfg_rdy, .cmd_vld, .cmd, .cmd_rdy,
        .wr_last_fire, .out_last_fire, .in_en, .out_en, .clear, .cfg_q
    );

    glb_addr_counter cnt_i (
        .clk, .rst_n, .clear, .num_words(cfg_num_words(cfg_q)), .wr_fire,
        .rd_addr_fire, .rd_data_fire, .wr_cnt, .rd_addr_cnt, .rd_issue_done, .data_last
    );

    port_to_word_packer pack_i (
        .clk, .rst_n, .clear, .in_en, .in_dat, .in_vld, .in_last, .in_rdy,
        .word_o(pack_s.src)
    );

    word_fifo fifo_i (
        .clk, .rst_n, .clear, .push_s(pack_s.snk), .pop_s(fifo_s.src)
    );

    word_to_port_unpacker unpack_i (
        .clk, .rst_n, .clear, .out_en, .rd_dat, .rd_dat_vld, .data_last, .rd_dat_rdy,
        .out_dat, .out_vld, .out_last, .out_rdy
    );

endmodule

`default_nettype wire

/* testbench/tb_gic_top.sv */
// Directed testbench for gic_top with GLB and off-chip port models; run it as the simulation top
`default_nettype none

module tb_gic_top
    import gic_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ====================
    // Run constants
    // ====================
    localparam int CLK_PERIOD      = 10;
    localparam int DRV_DLY         = 1;
    localparam int SEED            = 48;
    localparam int CYCLES_PER_WORD = 200;
    // Words per test
    localparam int N_CMD           = 1;
    localparam int N_IN            = 4;
    localparam int N_OUT           = 4;
    localparam int N_WRAP          = 6;
    localparam int N_B2B           = 5;
    localparam int TOTAL_WORDS     = N_CMD + N_IN + N_OUT + 2 * N_WRAP + 2 * N_B2B;
    localparam int WATCHDOG_CYCLES = CYCLES_PER_WORD * TOTAL_WORDS;

    logic       clk;
    logic       rst_n;
    logic       cfg_vld;
    logic       cfg_rdy;
    cfg_info_t  cfg_info;
    logic       cmd_vld;
    cmd_t       cmd;
    logic       cmd_rdy;
    port_data_t out_dat;
    logic       out_vld;
    logic       out_last;
    logic       out_rdy;
    port_data_t in_dat;
    logic       in_vld;
    logic       in_last;
    logic       in_rdy;
    glb_addr_t  rd_addr;
    logic       rd_addr_vld;
    logic       rd_addr_rdy;
    glb_word_t  rd_dat;
    logic       rd_dat_vld;
    logic       rd_dat_rdy;
    glb_addr_t  wr_addr;
    glb_word_t  wr_dat;
    logic       wr_vld;
    logic       wr_rdy;

    // GLB contents and observed traffic
    glb_word_t   glb_mem [256];
    glb_addr_t   wr_addr_log [$];
    glb_word_t   wr_dat_log [$];
    port_data_t  out_dat_log [$];
    logic        out_last_log [$];
    port_data_t  sent_beats [$];
    port_data_t  exp_beats [$];
    int unsigned cycle_cnt = 0;
    int unsigned last_fire_cycle = 0;
    // Random back-pressure on the GLB and outbound port
    logic        stall_en;

    gic_top dut_i (
        .clk, .rst_n, .cfg_vld, .cfg_rdy, .cfg_info, .cmd_vld, .cmd, .cmd_rdy,
        .out_dat, .out_vld, .out_last, .out_rdy, .in_dat, .in_vld, .in_last, .in_rdy,
        .rd_addr, .rd_addr_vld, .rd_addr_rdy, .rd_dat, .rd_dat_vld, .rd_dat_rdy,
        .wr_addr, .wr_dat, .wr_vld, .wr_rdy
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Reporting
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("** Error at %0t: %s expected 0x%0h, got 0x%0h",
                                $time, name, exp, act));
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    // Config layout from the MSB down: glb_base, dram_base, num_words, dir
    function automatic cfg_info_t make_cfg(input glb_addr_t glb, input dram_addr_t dram,
                                           input word_count_t n, input logic dir);
        return {glb, dram, n, dir};
    endfunction

    // Background fill, every address bit shows up
    function automatic glb_word_t fill_word(input glb_addr_t a);
        return {8'hA5, a, ~a, a ^ 8'h3C};
    endfunction

    // ====================
    // Models
    // ====================
    // Handshakes counted on the clock edge, inputs are stable there
    always @(posedge clk) begin
        if (wr_vld && wr_rdy) begin
            glb_mem[wr_addr] = wr_dat;
            wr_addr_log.push_back(wr_addr);
            wr_dat_log.push_back(wr_dat);
            last_fire_cycle = cycle_cnt;
        end
        if (out_vld && out_rdy) begin
            out_dat_log.push_back(out_dat);
            out_last_log.push_back(out_last);
            last_fire_cycle = cycle_cnt;
        end
        cycle_cnt = cycle_cnt + 1;
    end

    task automatic drive_readies();
        forever begin
            wait_cycle();
            wr_rdy      = stall_en ? ($urandom_range(0, 2) != 0) : 1'b1;
            rd_addr_rdy = stall_en ? ($urandom_range(0, 2) != 0) : 1'b1;
            out_rdy     = stall_en ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    endtask

    // In-order read returns, 1 to 3 cycles after the address
    task automatic serve_glb_reads();
        glb_addr_t   addr_q [$];
        int unsigned due_q [$];
        int unsigned now;
        now = 0;
        forever begin
            @(posedge clk);
            now++;
            if (rd_dat_vld && rd_dat_rdy) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (rd_addr_vld && rd_addr_rdy) begin
                addr_q.push_back(rd_addr);
                due_q.push_back(now + $urandom_range(1, 3));
            end
            #DRV_DLY;
            if (addr_q.size() > 0 && due_q[0] <= now) begin
                rd_dat_vld = 1'b1;
                rd_dat     = glb_mem[addr_q[0]];
            end else begin
                rd_dat_vld = 1'b0;
            end
        end
    endtask

    // ====================
    // Transfer steps
    // ====================
    task automatic clear_logs();
        wr_addr_log.delete();
        wr_dat_log.delete();
        out_dat_log.delete();
        out_last_log.delete();
    endtask

    // Config handshake, then command beat held through cmd_rdy stalls
    task automatic start_transfer(input glb_addr_t glb, input dram_addr_t dram,
                                  input word_count_t n, input logic dir, input int stall);
        cmd_t exp_cmd;
        exp_cmd = {dram, n, dir};
        expect_value("cfg_rdy", 1, cfg_rdy);
        cfg_info = make_cfg(glb, dram, n, dir);
        cfg_vld  = 1'b1;
        wait_cycle();
        cfg_vld  = 1'b0;
        expect_value("cfg_rdy", 0, cfg_rdy);
        repeat (stall) begin
            expect_value("cmd_vld", 1, cmd_vld);
            expect_value("cmd", exp_cmd, cmd);
            wait_cycle();
        end
        expect_value("cmd_vld", 1, cmd_vld);
        expect_value("cmd", exp_cmd, cmd);
        cmd_rdy = 1'b1;
        wait_cycle();
        cmd_rdy = 1'b0;
        expect_value("cmd_vld", 0, cmd_vld);
        // Data path open right after the command
        if (dir) begin
            expect_value("rd_addr_vld", 1, rd_addr_vld);
        end else begin
            expect_value("in_rdy", 1, in_rdy);
        end
    endtask

    task automatic send_beats(input word_count_t n);
        int   total;
        logic taken;
        total = 2 * n;
        sent_beats.delete();
        for (int j = 0; j < total; j++) begin
            sent_beats.push_back(port_data_t'($urandom_range(0, 16'hFFFF)));
            in_dat  = sent_beats[j];
            in_vld  = 1'b1;
            in_last = (j == total - 1);
            taken   = 1'b0;
            while (!taken) begin
                taken = in_rdy;
                wait_cycle();
            end
        end
        in_vld  = 1'b0;
        in_last = 1'b0;
    endtask

    // cfg_rdy must come back exactly one cycle after the final handshake
    task automatic wait_idle(input word_count_t n);
        int waited;
        waited = 0;
        while (!cfg_rdy) begin
            if (waited >= CYCLES_PER_WORD * n) begin
                abort_run("Transfer did not return to idle in time");
            end else begin
                wait_cycle();
                waited++;
            end
        end
        expect_value("cycles from final handshake to cfg_rdy", 1, cycle_cnt - last_fire_cycle);
    endtask

    task automatic verify_writes(input glb_addr_t glb, input word_count_t n);
        glb_addr_t a;
        glb_word_t w;
        expect_value("GLB write count", n, wr_addr_log.size());
        expect_value("outbound beat count", 0, out_dat_log.size());
        for (int i = 0; i < n; i++) begin
            a = glb_addr_t'(glb + i);
            // Low half is the earlier beat
            w = {sent_beats[2 * i + 1], sent_beats[2 * i]};
            expect_value($sformatf("wr_addr[%0d]", i), a, wr_addr_log[i]);
            expect_value($sformatf("wr_dat[%0d]", i), w, wr_dat_log[i]);
            expect_value($sformatf("glb_mem[0x%0h]", a), w, glb_mem[a]);
        end
    endtask

    task automatic compare_beats(input word_count_t n);
        int total;
        total = 2 * n;
        expect_value("outbound beat count", total, out_dat_log.size());
        expect_value("GLB write count", 0, wr_addr_log.size());
        for (int i = 0; i < total; i++) begin
            expect_value($sformatf("out_dat[%0d]", i), exp_beats[i], out_dat_log[i]);
            expect_value($sformatf("out_last[%0d]", i), (i == total - 1), out_last_log[i]);
        end
    endtask

    // Random words into the region, expected beats low half first
    task automatic preload_region(input glb_addr_t glb, input word_count_t n);
        glb_word_t w;
        exp_beats.delete();
        for (int i = 0; i < n; i++) begin
            w = glb_word_t'($urandom);
            glb_mem[glb_addr_t'(glb + i)] = w;
            exp_beats.push_back(w[15:0]);
            exp_beats.push_back(w[31:16]);
        end
    endtask

    task automatic run_in(input glb_addr_t glb, input dram_addr_t dram,
                          input word_count_t n, input int stall);
        clear_logs();
        start_transfer(glb, dram, n, 1'b0, stall);
        send_beats(n);
        wait_idle(n);
        verify_writes(glb, n);
    endtask

    task automatic run_out(input glb_addr_t glb, input dram_addr_t dram,
                           input word_count_t n, input int stall);
        clear_logs();
        start_transfer(glb, dram, n, 1'b1, stall);
        wait_idle(n);
        compare_beats(n);
    endtask

    // ====================
    // Tests
    // ====================
    task automatic reset_state_check();
        expect_value("cfg_rdy", 1, cfg_rdy);
        expect_value("cmd_vld", 0, cmd_vld);
        expect_value("out_vld", 0, out_vld);
        expect_value("in_rdy", 0, in_rdy);
        expect_value("rd_addr_vld", 0, rd_addr_vld);
        expect_value("rd_dat_rdy", 0, rd_dat_rdy);
        expect_value("wr_vld", 0, wr_vld);
    endtask

    task automatic command_beat_stalls();
        stall_en = 1'b0;
        run_in(8'h10, 16'hBEEF, N_CMD, 4);
    endtask

    task automatic in_to_chip_transfer();
        stall_en = 1'b0;
        run_in(8'h20, 16'h1000, N_IN, 0);
    endtask

    task automatic out_to_off_transfer();
        stall_en = 1'b0;
        preload_region(8'h40, N_OUT);
        run_out(8'h40, 16'h2000, N_OUT, 0);
    endtask

    // Both regions cross address 255
    task automatic stalls_and_wrap();
        stall_en = 1'b1;
        run_in(8'hFD, 16'h3000, N_WRAP, 2);
        preload_region(8'hFB, N_WRAP);
        run_out(8'hFB, 16'h3100, N_WRAP, 1);
    endtask

    // Read back the region just written, no idle gap
    task automatic back_to_back_transfers();
        stall_en = 1'b1;
        run_in(8'h80, 16'h4000, N_B2B, 1);
        exp_beats = sent_beats;
        run_out(8'h80, 16'h4000, N_B2B, 0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        cfg_vld     = 1'b0;
        cfg_info    = '0;
        cmd_rdy     = 1'b0;
        out_rdy     = 1'b0;
        in_dat      = '0;
        in_vld      = 1'b0;
        in_last     = 1'b0;
        rd_addr_rdy = 1'b0;
        rd_dat      = '0;
        rd_dat_vld  = 1'b0;
        wr_rdy      = 1'b0;
        stall_en    = 1'b0;
        for (int a = 0; a < 256; a++) begin
            glb_mem[a] = fill_word(glb_addr_t'(a));
        end
        // Models inherit the seeded generator
        fork
            drive_readies();
            serve_glb_reads();
        join_none
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        reset_state_check();
        command_beat_stalls();
        in_to_chip_transfer();
        out_to_off_transfer();
        stalls_and_wrap();
        back_to_back_transfers();
        $display("Done: no errors");
        $finish;
    end

    // Run limit scaled by the words moved
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $fatal(1, "Watchdog timeout");
    end

endmodule

`default_nettype wire

/* flist.f */
logic/gic_pkg.sv
logic/word_stream_if.sv
logic/gic_ctrl_fsm.sv
logic/glb_addr_counter.sv
logic/port_to_word_packer.sv
logic/word_fifo.sv
logic/word_to_port_unpacker.sv
logic/gic_top.sv
testbench/tb_gic_top.sv

/* Bender.yml */
package:
  name: gic

sources:
  - target: any(rtl, test)
    files:
      - logic/gic_pkg.sv
      - logic/word_stream_if.sv
      - logic/gic_ctrl_fsm.sv
      - logic/glb_addr_counter.sv
      - logic/port_to_word_packer.sv
      - logic/word_fifo.sv
      - logic/word_to_port_unpacker.sv
      - logic/gic_top.sv
  - target: test
    files:
      - testbench/tb_gic_top.sv
